// File: sources.f
+incdir+hw
hw/arm_pkg.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/armv4_core.sv
testbench/tb_armv4_core.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then look for the fail line in sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_armv4_core -f sources.f -o sim_tb \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"
exit 0

// File: testbench/tb_armv4_core.sv
`timescale 1ns/10ps
`include "arm_cfg.svh"

module tb_armv4_core;
    localparam int NUM_RETIRES = 600;
    localparam int IDLE_LIMIT  = 200;

    typedef logic [127:0] wide_t;

    logic                   clk;
    logic                   i_rst_n;
    logic                   o_rom_en;
    arm_pkg::word_t         o_rom_addr;
    arm_pkg::word_t         i_rom_data;
    arm_pkg::retire_t       o_retire;
    logic                   o_retire_valid;
    logic                   i_retire_ready;

    arm_pkg::word_t         rom [256];
    logic                   rom_pending;                // request seen, data due next cycle
    arm_pkg::word_t         rom_req_addr;
    arm_pkg::word_t         fetch_pc;                   // next address fetch should request
    arm_pkg::word_t         model_regs [15];
    arm_pkg::nzcv_t         model_nzcv;
    arm_pkg::word_t         exp_pc;

    armv4_core uut (
        .clk                (clk                    ),
        .i_rst_n            (i_rst_n                ),
        .o_rom_en           (o_rom_en               ),
        .o_rom_addr         (o_rom_addr             ),
        .i_rom_data         (i_rom_data             ),
        .o_retire           (o_retire               ),
        .o_retire_valid     (o_retire_valid         ),
        .i_retire_ready     (i_retire_ready         )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input wide_t expected, input wide_t actual);
        if (expected !== actual) begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program generation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic arm_pkg::word_t random_inst();
        logic [3:0] cond;
        logic [3:0] op;
        logic       imm;
        logic       s;
        logic [3:0] rn;
        logic [3:0] rd;
        logic [3:0] rm;
        logic [7:0] imm8;
        case ($urandom_range(0, 6))
            0:       cond = arm_pkg::COND_EQ;
            1:       cond = arm_pkg::COND_NE;
            2:       cond = arm_pkg::COND_CS;
            3:       cond = arm_pkg::COND_CC;
            4:       cond = arm_pkg::COND_MI;
            5:       cond = arm_pkg::COND_PL;
            default: cond = arm_pkg::COND_AL;
        endcase
        if ($urandom_range(0, 7) == 0) begin          // unsupported opcode
            case ($urandom_range(0, 8))
                0:       op = 4'd3;
                1:       op = 4'd5;
                2:       op = 4'd6;
                3:       op = 4'd7;
                4:       op = 4'd8;
                5:       op = 4'd9;
                6:       op = 4'd11;
                7:       op = 4'd14;
                default: op = 4'd15;
            endcase
        end else begin
            case ($urandom_range(0, 6))
                0:       op = arm_pkg::OP_AND;
                1:       op = arm_pkg::OP_EOR;
                2:       op = arm_pkg::OP_SUB;
                3:       op = arm_pkg::OP_ADD;
                4:       op = arm_pkg::OP_CMP;
                5:       op = arm_pkg::OP_ORR;
                default: op = arm_pkg::OP_MOV;
            endcase
        end
        imm  = 1'($urandom_range(0, 1));
        s    = 1'($urandom_range(0, 1));
        rn   = 4'($urandom_range(0, 14));
        rd   = 4'($urandom_range(0, 14));
        rm   = 4'($urandom_range(0, 14));
        imm8 = 8'($urandom);
        return {cond, 2'b00, imm, op, s, rn, rd, imm ? {4'd0, imm8} : {8'd0, rm}};
    endfunction

    function automatic logic cond_holds(input logic [3:0] cond, input arm_pkg::nzcv_t f);
        case (cond)
            arm_pkg::COND_EQ: return f[2];
            arm_pkg::COND_NE: return !f[2];
            arm_pkg::COND_CS: return f[1];
            arm_pkg::COND_CC: return !f[1];
            arm_pkg::COND_MI: return f[3];
            arm_pkg::COND_PL: return !f[3];
            arm_pkg::COND_AL: return 1'b1;
            default:          return 1'b0;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_retire(input arm_pkg::retire_t r);
        arm_pkg::word_t inst;
        arm_pkg::word_t a;
        arm_pkg::word_t b;
        arm_pkg::word_t res;
        logic [3:0]     op;
        logic           known;
        logic           exec;
        logic           wr;
        logic           flags;
        logic           c;
        logic           v;
        longint         sum;
        inst  = rom[exp_pc[9:2]];
        op    = inst[24:21];
        a     = model_regs[inst[19:16]];
        if (inst[25]) begin
            b = {24'd0, inst[7:0]};
        end else begin
            b = model_regs[inst[3:0]];
        end
        known = 1'b1;
        c     = model_nzcv[1];
        v     = model_nzcv[0];
        res   = '0;
        case (op)
            arm_pkg::OP_AND: res = a & b;
            arm_pkg::OP_EOR: res = a ^ b;
            arm_pkg::OP_ORR: res = a | b;
            arm_pkg::OP_MOV: res = b;
            arm_pkg::OP_ADD: begin
                res = a + b;
                c   = (res < a);                        // wrapped means carry out
                sum = longint'($signed(a)) + longint'($signed(b));
                v   = (sum != longint'($signed(res)));
            end
            arm_pkg::OP_SUB, arm_pkg::OP_CMP: begin
                res = a - b;
                c   = (a >= b);                         // no borrow
                sum = longint'($signed(a)) - longint'($signed(b));
                v   = (sum != longint'($signed(res)));
            end
            default: known = 1'b0;
        endcase
        exec  = known && cond_holds(inst[31:28], model_nzcv);
        wr    = exec && (op != arm_pkg::OP_CMP);
        flags = exec && (inst[20] || op == arm_pkg::OP_CMP);
        if (flags) begin
            model_nzcv = {res[31], (res == 32'd0), c, v};
        end
        check_value("retire pc", wide_t'(exp_pc), wide_t'(r.pc));
        check_value("executed", wide_t'(exec), wide_t'(r.executed));
        check_value("wr_en", wide_t'(wr), wide_t'(r.wr_en));
        if (wr) begin
            check_value("rd", wide_t'(inst[15:12]), wide_t'(r.rd));
            model_regs[inst[15:12]] = res;
        end
        check_value("value", wide_t'(wr ? res : 32'd0), wide_t'(r.value));
        check_value("nzcv", wide_t'(model_nzcv), wide_t'(r.nzcv));
        exp_pc = exp_pc + `ARM_PC_STEP;
    endtask

    initial begin
        int               idle;
        int               retired;
        logic             stalled;
        arm_pkg::retire_t held;
        void'($urandom(32'ha62b));
        i_rst_n        = 1'b0;
        i_retire_ready = 1'b0;
        i_rom_data     = '0;
        rom_pending    = 1'b0;
        rom_req_addr   = '0;
        fetch_pc       = `ARM_RESET_PC;
        model_nzcv     = '0;
        exp_pc         = `ARM_RESET_PC;
        for (int i = 0; i < 15; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            rom[i] = random_inst();
        end
        idle    = 0;
        retired = 0;
        stalled = 1'b0;
        held    = '0;
        repeat (10) begin
            @(negedge clk);
            check_value("rom_en in reset", '0, wide_t'(o_rom_en));
            check_value("retire_valid in reset", '0, wide_t'(o_retire_valid));
        end
        i_rst_n = 1'b1;
        while (retired < NUM_RETIRES) begin
            @(negedge clk);
            if (stalled) begin                          // held retire must not move
                check_value("retire_valid held", wide_t'(1'b1), wide_t'(o_retire_valid));
                check_value("retire held", wide_t'(held), wide_t'(o_retire));
            end
            if (rom_pending) begin
                i_rom_data = rom[rom_req_addr[9:2]];
            end
            if (o_rom_en) begin
                check_value("rom address", wide_t'(fetch_pc), wide_t'(o_rom_addr));
                fetch_pc = fetch_pc + `ARM_PC_STEP;
            end
            rom_pending    = o_rom_en;
            rom_req_addr   = o_rom_addr;
            i_retire_ready = ($urandom_range(0, 9) < 7);
            if (o_retire_valid && i_retire_ready) begin
                check_retire(o_retire);                 // accepted at the next edge
                retired++;
                idle = 0;
            end else begin
                idle++;
                if (idle > IDLE_LIMIT) begin
                    $display("no retire was accepted for %0d cycles", IDLE_LIMIT);
                    stop_with_failure();
                end
            end
            stalled = o_retire_valid && !i_retire_ready;
            held    = o_retire;
        end
        $display("Finished with no errors");
        $finish;
    end
endmodule

// File: hw/armv4_core.sv
`timescale 1ns/10ps

module armv4_core (
    input  logic                clk,
    input  logic                i_rst_n,

    // rom bus
    output logic                o_rom_en,
    output arm_pkg::word_t      o_rom_addr,
    input  arm_pkg::word_t      i_rom_data,

    // retire port
    output arm_pkg::retire_t    o_retire,
    output logic                o_retire_valid,
    input  logic                i_retire_ready
);
    arm_pkg::fetch_t            fetch_data;
    logic                       fetch_valid;
    logic                       fetch_ready;
    arm_pkg::fetch_t            queue_data;
    logic                       queue_valid;
    logic                       queue_ready;

    fetch_unit fetch_unit_0 (
        .clk                (clk                    ),
        .i_rst_n            (i_rst_n                ),
        .o_rom_en           (o_rom_en               ),
        .o_rom_addr         (o_rom_addr             ),
        .i_rom_data         (i_rom_data             ),
        .o_fetch            (fetch_data             ),
        .o_fetch_valid      (fetch_valid            ),
        .i_fetch_ready      (fetch_ready            )
    );

    inst_queue inst_queue_0 (
        .clk                (clk                    ),
        .i_rst_n            (i_rst_n                ),
        .i_push             (fetch_data             ),
        .i_push_valid       (fetch_valid            ),
        .o_push_ready       (fetch_ready            ),
        .o_pop              (queue_data             ),
        .o_pop_valid        (queue_valid            ),
        .i_pop_ready        (queue_ready            )
    );

    exec_unit exec_unit_0 (
        .clk                (clk                    ),
        .i_rst_n            (i_rst_n                ),
        .i_inst             (queue_data             ),
        .i_inst_valid       (queue_valid            ),
        .o_inst_ready       (queue_ready            ),
        .o_retire           (o_retire               ),
        .o_retire_valid     (o_retire_valid         ),
        .i_retire_ready     (i_retire_ready         )
    );
endmodule

// File: hw/exec_unit.sv
`timescale 1ns/10ps
`include "arm_cfg.svh"

module exec_unit (
    input  logic                clk,
    input  logic                i_rst_n,

    input  arm_pkg::fetch_t     i_inst,
    input  logic                i_inst_valid,
    output logic                o_inst_ready,

    output arm_pkg::retire_t    o_retire,
    output logic                o_retire_valid,
    input  logic                i_retire_ready
);
    arm_pkg::cond_t             cond;
    logic                       imm_flag;
    arm_pkg::alu_op_t           opcode;
    logic                       s_flag;
    arm_pkg::reg_code_t         rn_code;
    arm_pkg::reg_code_t         rd_code;
    arm_pkg::reg_code_t         rm_code;
    arm_pkg::word_t             rn_reg;
    arm_pkg::word_t             rm_reg;
    arm_pkg::word_t             op2;

    arm_pkg::nzcv_t             nzcv_q;
    arm_pkg::nzcv_t             nzcv_next;
    logic                       cond_pass;
    logic                       op_supported;
    logic                       executed;
    logic                       wr_en;
    logic                       flags_en;
    logic [`ARM_XLEN:0]         add_sum;
    logic [`ARM_XLEN:0]         sub_diff;
    arm_pkg::word_t             result;
    logic                       carry;
    logic                       overflow;
    logic                       take;
    arm_pkg::retire_t           retire_q;
    logic                       retire_valid_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode and operands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign cond     = arm_pkg::cond_t'(i_inst.inst[31:28]);
    assign imm_flag = i_inst.inst[25];
    assign opcode   = arm_pkg::alu_op_t'(i_inst.inst[24:21]);
    assign s_flag   = i_inst.inst[20];
    assign rn_code  = i_inst.inst[19:16];
    assign rd_code  = i_inst.inst[15:12];
    assign rm_code  = i_inst.inst[3:0];

    reg_file reg_file_0 (
        .clk                (clk                    ),
        .i_rst_n            (i_rst_n                ),
        .i_rn_code          (rn_code                ),
        .i_rm_code          (rm_code                ),
        .o_rn_reg           (rn_reg                 ),
        .o_rm_reg           (rm_reg                 ),
        .i_wr_en            (take && wr_en          ),
        .i_wr_code          (rd_code                ),
        .i_wr_data          (result                 )
    );

    assign op2 = imm_flag ? arm_pkg::word_t'(i_inst.inst[7:0]) : rm_reg;    // no rotate

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // condition check and alu
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (cond)
            arm_pkg::COND_EQ: cond_pass = nzcv_q[2];
            arm_pkg::COND_NE: cond_pass = !nzcv_q[2];
            arm_pkg::COND_CS: cond_pass = nzcv_q[1];
            arm_pkg::COND_CC: cond_pass = !nzcv_q[1];
            arm_pkg::COND_MI: cond_pass = nzcv_q[3];
            arm_pkg::COND_PL: cond_pass = !nzcv_q[3];
            arm_pkg::COND_AL: cond_pass = 1'b1;
            default:          cond_pass = 1'b0;
        endcase
    end

    assign add_sum  = {1'b0, rn_reg} + {1'b0, op2};
    assign sub_diff = {1'b0, rn_reg} + {1'b0, ~op2} + 1'b1;    // carry is not borrow

    always_comb begin
        op_supported = 1'b1;
        carry        = nzcv_q[1];                   // logic ops keep c and v
        overflow     = nzcv_q[0];
        case (opcode)
            arm_pkg::OP_AND: result = rn_reg & op2;
            arm_pkg::OP_EOR: result = rn_reg ^ op2;
            arm_pkg::OP_ORR: result = rn_reg | op2;
            arm_pkg::OP_MOV: result = op2;
            arm_pkg::OP_ADD: begin
                result   = add_sum[`ARM_XLEN-1:0];
                carry    = add_sum[`ARM_XLEN];
                overflow = (rn_reg[`ARM_XLEN-1] == op2[`ARM_XLEN-1]) &&
                           (result[`ARM_XLEN-1] != rn_reg[`ARM_XLEN-1]);
            end
            arm_pkg::OP_SUB, arm_pkg::OP_CMP: begin
                result   = sub_diff[`ARM_XLEN-1:0];
                carry    = sub_diff[`ARM_XLEN];
                overflow = (rn_reg[`ARM_XLEN-1] != op2[`ARM_XLEN-1]) &&
                           (result[`ARM_XLEN-1] != rn_reg[`ARM_XLEN-1]);
            end
            default: begin
                result       = '0;
                op_supported = 1'b0;
            end
        endcase
    end

    assign executed  = cond_pass && op_supported;
    assign wr_en     = executed && (opcode != arm_pkg::OP_CMP);
    assign flags_en  = executed && (s_flag || opcode == arm_pkg::OP_CMP);
    assign nzcv_next = flags_en ? {result[`ARM_XLEN-1], (result == '0), carry, overflow}
                                : nzcv_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // retire register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign o_inst_ready   = !retire_valid_q || i_retire_ready;
    assign take           = i_inst_valid && o_inst_ready;
    assign o_retire       = retire_q;
    assign o_retire_valid = retire_valid_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            retire_valid_q <= 1'b0;
            nzcv_q         <= '0;
        end else if (take) begin
            retire_valid_q <= 1'b1;
            nzcv_q         <= nzcv_next;            // same edge as the reg write
        end else if (i_retire_ready) begin
            retire_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            retire_q.pc       <= i_inst.pc;
            retire_q.executed <= executed;
            retire_q.wr_en    <= wr_en;
            retire_q.rd       <= rd_code;
            retire_q.value    <= wr_en ? result : '0;
            retire_q.nzcv     <= nzcv_next;
        end
    end
endmodule

// File: hw/reg_file.sv
`timescale 1ns/10ps
`include "arm_cfg.svh"

module reg_file (
    input  logic                clk,
    input  logic                i_rst_n,

    input  arm_pkg::reg_code_t  i_rn_code,
    input  arm_pkg::reg_code_t  i_rm_code,
    output arm_pkg::word_t      o_rn_reg,
    output arm_pkg::word_t      o_rm_reg,

    input  logic                i_wr_en,
    input  arm_pkg::reg_code_t  i_wr_code,
    input  arm_pkg::word_t      i_wr_data
);
    arm_pkg::word_t             regs [`ARM_NREGS];

    assign o_rn_reg = regs[i_rn_code];              // async read
    assign o_rm_reg = regs[i_rm_code];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `ARM_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en) begin
            regs[i_wr_code] <= i_wr_data;
        end
    end
endmodule

// File: hw/inst_queue.sv
`timescale 1ns/10ps
`include "arm_cfg.svh"

module inst_queue #(
    parameter int DEPTH = `ARM_QUEUE_DEPTH
) (
    input  logic                clk,
    input  logic                i_rst_n,

    input  arm_pkg::fetch_t     i_push,
    input  logic                i_push_valid,
    output logic                o_push_ready,

    output arm_pkg::fetch_t     o_pop,
    output logic                o_pop_valid,
    input  logic                i_pop_ready
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    arm_pkg::fetch_t            mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;
    logic                       push;
    logic                       pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_push_ready = (count != CNT_W'(DEPTH));
    assign o_pop_valid  = (count != '0);
    assign o_pop        = mem[rd_ptr];
    assign push         = i_push_valid && o_push_ready;
    assign pop          = o_pop_valid && i_pop_ready;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_push;
        end
    end
endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/10ps
`include "arm_cfg.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                i_rst_n,

    output logic                o_rom_en,
    output arm_pkg::word_t      o_rom_addr,
    input  arm_pkg::word_t      i_rom_data,

    output arm_pkg::fetch_t     o_fetch,
    output logic                o_fetch_valid,
    input  logic                i_fetch_ready
);
    logic                       run;
    arm_pkg::word_t             pc;
    logic                       inflight;
    arm_pkg::word_t             inflight_pc;
    logic                       held;
    arm_pkg::fetch_t            held_slot;
    logic                       slot_free;

    // slot shows the rom word in its return cycle, the held copy after that
    assign o_fetch_valid = inflight || held;
    assign slot_free     = !o_fetch_valid || i_fetch_ready;
    assign o_rom_en      = run && slot_free;
    assign o_rom_addr    = pc;

    always_comb begin
        if (held) begin
            o_fetch = held_slot;
        end else begin
            o_fetch.pc   = inflight_pc;
            o_fetch.inst = i_rom_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            run      <= 1'b0;
            pc       <= `ARM_RESET_PC;
            inflight <= 1'b0;
            held     <= 1'b0;
        end else begin
            run      <= 1'b1;                       // first request after reset release
            inflight <= o_rom_en;
            if (o_rom_en) begin
                pc <= pc + `ARM_PC_STEP;
            end
            if (inflight && !i_fetch_ready) begin
                held <= 1'b1;                       // word not taken, keep a copy
            end else if (i_fetch_ready) begin
                held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_rom_en) begin
            inflight_pc <= pc;
        end
        if (inflight && !i_fetch_ready) begin
            held_slot <= o_fetch;
        end
    end
endmodule

// File: hw/arm_pkg.sv
`include "arm_cfg.svh"

package arm_pkg;

    typedef logic [`ARM_XLEN-1:0]   word_t;
    typedef logic [3:0]             reg_code_t;
    typedef logic [3:0]             nzcv_t;         // n z c v, n on top

    // data processing opcodes, bits 24:21
    typedef enum logic [3:0] {
        OP_AND = 4'd0,
        OP_EOR = 4'd1,
        OP_SUB = 4'd2,
        OP_ADD = 4'd4,
        OP_CMP = 4'd10,
        OP_ORR = 4'd12,
        OP_MOV = 4'd13
    } alu_op_t;

    // condition field, bits 31:28
    typedef enum logic [3:0] {
        COND_EQ = 4'd0,
        COND_NE = 4'd1,
        COND_CS = 4'd2,
        COND_CC = 4'd3,
        COND_MI = 4'd4,
        COND_PL = 4'd5,
        COND_AL = 4'd14
    } cond_t;

    typedef struct packed {
        word_t      pc;
        word_t      inst;
    } fetch_t;

    typedef struct packed {
        word_t      pc;
        logic       executed;                       // cond passed, opcode known
        logic       wr_en;
        reg_code_t  rd;
        word_t      value;                          // zero when nothing written
        nzcv_t      nzcv;
    } retire_t;

endpackage

// File: hw/arm_cfg.svh
`ifndef ARM_CFG_SVH
`define ARM_CFG_SVH

// datapath
`define ARM_XLEN            32
`define ARM_NREGS           16

// fetch to execute decoupling
`define ARM_QUEUE_DEPTH     2

// program counter
`define ARM_RESET_PC        32'h0000_0000
`define ARM_PC_STEP         32'd4

`endif
